/* all.f */
+incdir+bench
rtl/qbv_pkg.sv
rtl/gcl_wr_if.sv
rtl/gcl_loader.sv
rtl/gcl_banks.sv
rtl/base_time_cmp.sv
rtl/gate_list_sched.sv
rtl/qbv_gate_ctrl.sv
bench/tb_qbv_gate_ctrl.sv

/* bench/tb_qbv_model.svh */
// Schedule model; assumes the current time advances TICK_NS per clock and lists never overlap
`ifndef TB_QBV_MODEL_SVH
`define TB_QBV_MODEL_SVH

localparam int INTERVAL_NS  = 80;
localparam int INTERVAL_CYC = INTERVAL_NS / TICK_NS;        // 10 clocks per entry
localparam int RUN_LATENCY  = 7;                            // Time reached to first entry seen
localparam int BASE_LEAD_NS = 40 * TICK_NS;
localparam int LEN_A        = 5;
localparam int LEN_B        = 3;
localparam int LEN_C        = 4;
localparam int WATCHDOG_CYCLES = (LEN_A + 2 * LEN_B + 2 * LEN_C) * INTERVAL_CYC + 600;

integer    seed = 32'h12e2_ce14;
int        err_cnt = 0;
int        chk_cnt = 0;

// --------------------
// Model state
gate_vec_t model_list[$];
gate_vec_t model_next[$];                                   // List waiting for the swap
gate_vec_t model_queue_q = '0;
logic      model_vld_q = 1'b0;
logic      model_armed = 1'b0;
logic      model_starting = 1'b0;
logic      model_running = 1'b0;
logic      model_pending = 1'b0;
ptp_time_t model_base = '0;
int        model_entry = 0;
int        model_phase = 0;
int        model_start_cyc = 0;
int        cyc_cnt = 0;
int        pass_cnt = 0;

// Gates open only while a list runs
function automatic gate_vec_t current_entry();
    if (model_running) begin
        return model_list[model_entry];
    end
    return '0;
endfunction

function automatic gate_vec_t expected_gate(input logic en, input gate_vec_t queue_q,
                                            input gate_vec_t entry);
    return en ? (queue_q & entry) : queue_q;
endfunction

// Skip the clocks around entry boundaries and the start of a run
function automatic logic in_check_window();
    if (model_running) begin
        return (model_phase >= 2) && (model_phase <= INTERVAL_CYC - 3);
    end
    return !model_starting;
endfunction

task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
    chk_cnt++;
    if (exp !== got) begin
        err_cnt++;
        $display("Fail %s exp=%h got=%h (%0t)", name, exp, got, $time);
    end
endtask

task automatic update_model(input logic refresh, input logic queue_vld,
                            input gate_vec_t queue, input ptp_time_t cur_time);
    if (queue_vld) begin
        model_queue_q = queue;
    end
    model_vld_q = queue_vld;
    if (refresh) begin
        model_armed    = 1'b0;
        model_starting = 1'b0;
        model_running  = 1'b0;
        model_pending  = 1'b0;
    end else if (model_running) begin
        model_phase++;
        if (model_phase == INTERVAL_CYC) begin
            model_phase = 0;
            model_entry++;
            if (model_entry == model_list.size()) begin
                model_entry = 0;
                pass_cnt++;
                if (model_pending) begin
                    model_list    = model_next;            // New list from entry 0
                    model_pending = 1'b0;
                end
            end
        end
    end else if (model_starting) begin
        if (cyc_cnt == model_start_cyc) begin
            model_starting = 1'b0;
            model_running  = 1'b1;
            model_entry    = 0;
            model_phase    = 0;
        end
    end else if (model_armed && cur_time >= model_base) begin
        model_starting  = 1'b1;
        model_start_cyc = cyc_cnt + RUN_LATENCY - 1;
    end
    cyc_cnt++;
endtask

`endif

/* bench/tb_qbv_gate_ctrl.sv */
// Needs a simulator with timing control; the watchdog bounds the run to a few hundred clocks
`timescale 1ns/100ps

module tb_qbv_gate_ctrl import qbv_pkg::*; ();

    logic      i_clk = 1'b0;
    logic      i_rst;
    gate_vec_t i_list_state;
    gcl_addr_t i_list_len;
    logic      i_list_vld;
    ptp_time_t i_base_time;
    logic      i_base_time_vld;
    ptp_time_t i_current_time;
    interval_t i_interval_ns;
    logic      i_refresh_list;
    logic      i_qbv_en;
    gate_vec_t i_queue;
    logic      i_queue_vld;
    gate_vec_t o_gate_state;
    logic      o_gate_state_vld;
    logic      o_base_time_err;
    logic      o_list_empty_err;

    `include "tb_qbv_model.svh"

    qbv_gate_ctrl i_dut (
        .i_clk            (i_clk),
        .i_rst            (i_rst),
        .i_list_state     (i_list_state),
        .i_list_len       (i_list_len),
        .i_list_vld       (i_list_vld),
        .i_base_time      (i_base_time),
        .i_base_time_vld  (i_base_time_vld),
        .i_current_time   (i_current_time),
        .i_interval_ns    (i_interval_ns),
        .i_refresh_list   (i_refresh_list),
        .i_qbv_en         (i_qbv_en),
        .i_queue          (i_queue),
        .i_queue_vld      (i_queue_vld),
        .o_gate_state     (o_gate_state),
        .o_gate_state_vld (o_gate_state_vld),
        .o_base_time_err  (o_base_time_err),
        .o_list_empty_err (o_list_empty_err)
    );

    always #5 i_clk = ~i_clk;

    // PTP time with upper slices nonzero
    initial begin
        i_current_time = 80'h0000_0123_4567_89ab_c000;
        forever begin
            @(negedge i_clk);
            i_current_time = i_current_time + ptp_time_t'(TICK_NS);
        end
    end

    // --------------------
    // Compare process
    always @(posedge i_clk) begin
        if (!i_rst) begin
            check_value("o_gate_state_vld", 32'(model_vld_q), 32'(o_gate_state_vld));
            if (o_gate_state_vld && in_check_window()) begin
                check_value("o_gate_state",
                            32'(expected_gate(i_qbv_en, model_queue_q, current_entry())),
                            32'(o_gate_state));
            end
            update_model(i_refresh_list, i_queue_vld, i_queue, i_current_time);
        end
    end

    task automatic finish_run();
        $display("Checks: %0d, errors: %0d", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge i_clk);
        $display("Watchdog expired after %0d clocks, the schedule never completed",
                 WATCHDOG_CYCLES);
        err_cnt++;
        finish_run();
    end

    task automatic load_list(input int len);
        logic [31:0] rnd;
        model_next.delete();
        for (int i = 0; i < len; i++) begin
            @(negedge i_clk);
            rnd          = $random(seed);
            i_list_state = rnd[NUM_QUEUES-1:0];
            i_list_len   = gcl_addr_t'(len);
            i_list_vld   = 1'b1;
            model_next.push_back(rnd[NUM_QUEUES-1:0]);
        end
        @(negedge i_clk);
        i_list_vld = 1'b0;
        if (model_running) begin
            model_pending = 1'b1;
        end else begin
            model_list = model_next;
        end
    endtask

    task automatic strobe_base(input ptp_time_t base, input logic arm);
        @(negedge i_clk);
        i_base_time     = base;
        i_base_time_vld = 1'b1;
        if (arm) begin
            model_base  = base;
            model_armed = 1'b1;
        end
        @(negedge i_clk);
        i_base_time_vld = 1'b0;
    endtask

    // --------------------
    // Stimulus
    initial begin
        logic [31:0] rnd;
        i_rst           = 1'b1;
        i_list_state    = '0;
        i_list_len      = '0;
        i_list_vld      = 1'b0;
        i_base_time     = '0;
        i_base_time_vld = 1'b0;
        i_interval_ns   = interval_t'(INTERVAL_NS);
        i_refresh_list  = 1'b0;
        i_qbv_en        = 1'b0;
        i_queue         = '0;
        i_queue_vld     = 1'b0;
        repeat (8) @(negedge i_clk);
        i_rst = 1'b0;
        @(negedge i_clk);
        check_value("o_gate_state", 32'd0, 32'(o_gate_state));
        check_value("o_gate_state_vld", 32'd0, 32'(o_gate_state_vld));
        check_value("o_base_time_err", 32'd0, 32'(o_base_time_err));
        check_value("o_list_empty_err", 32'd0, 32'(o_list_empty_err));

        for (int n = 0; n < 20; n++) begin                  // Gating off so queues pass through
            rnd         = $random(seed);
            i_queue     = rnd[NUM_QUEUES-1:0];
            i_queue_vld = rnd[8];
            @(negedge i_clk);
        end

        // Scheduled run and then a second list swapped in
        i_queue_vld = 1'b1;
        i_qbv_en    = 1'b1;
        load_list(LEN_A);
        strobe_base(i_current_time + ptp_time_t'(BASE_LEAD_NS), 1'b1);
        while (!model_starting && !model_running) begin
            rnd     = $random(seed);
            i_queue = rnd[NUM_QUEUES-1:0];                 // Gates still closed
            @(negedge i_clk);
        end
        i_queue = '1;
        check_value("o_base_time_err", 32'd0, 32'(o_base_time_err));
        wait (model_running && model_entry == 1);
        load_list(LEN_B);
        wait (pass_cnt == 3);

        // Refresh and then both error cases
        @(negedge i_clk);
        i_refresh_list = 1'b1;
        @(negedge i_clk);
        i_refresh_list = 1'b0;
        repeat (3 * INTERVAL_CYC) @(negedge i_clk);
        strobe_base(i_current_time + ptp_time_t'(BASE_LEAD_NS * 100), 1'b0);
        check_value("o_list_empty_err", 32'd1, 32'(o_list_empty_err));
        @(negedge i_clk);
        check_value("o_list_empty_err", 32'd0, 32'(o_list_empty_err));
        load_list(LEN_C);
        strobe_base(i_current_time - ptp_time_t'(200), 1'b0);
        for (int k = 0; k < 8; k++) begin
            if (o_base_time_err) begin
                break;
            end
            @(negedge i_clk);
        end
        check_value("o_base_time_err", 32'd1, 32'(o_base_time_err));
        repeat (3 * INTERVAL_CYC) @(negedge i_clk);

        // New base time restarts the loaded list
        strobe_base(i_current_time + ptp_time_t'(BASE_LEAD_NS), 1'b1);
        wait (pass_cnt == 4);
        check_value("o_base_time_err", 32'd0, 32'(o_base_time_err));
        repeat (2) @(negedge i_clk);
        finish_run();
    end

endmodule

/* rtl/base_time_cmp.sv */
// time_reached lags i_current_time by 3 cycles and is held low for two cycles after a base strobe
`timescale 1ns/100ps

module base_time_cmp import qbv_pkg::*; (
    input  logic            i_clk,
    input  logic            i_rst,
    input  ptp_time_t       i_current_time,
    input  ptp_time_t       i_base_time,
    input  logic            i_base_time_vld,
    output logic            o_time_reached,
    output logic            o_base_time_err
);

    ptp_time_t             cur_q;
    ptp_time_t             base_q;
    logic                  vld_d1;
    logic                  vld_d2;
    logic [NUM_SLICES-1:0] slice_lt;
    logic [NUM_SLICES-1:0] slice_eq;
    logic                  cur_lt_base;
    logic                  cur_eq_base;

    // --------------------
    // Cycle 1 capture
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            cur_q  <= '0;
            base_q <= '0;
            vld_d1 <= 1'b0;
            vld_d2 <= 1'b0;
        end else begin
            cur_q  <= i_current_time;
            vld_d1 <= i_base_time_vld;
            vld_d2 <= vld_d1;
            if (i_base_time_vld) begin
                base_q <= i_base_time;
            end
        end
    end

    // Cycle 2 per-slice flags
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            slice_lt <= '0;
            slice_eq <= '0;
        end else begin
            for (int s = 0; s < NUM_SLICES; s++) begin
                slice_lt[s] <= cur_q[s*SLICE_W +: SLICE_W] < base_q[s*SLICE_W +: SLICE_W];
                slice_eq[s] <= cur_q[s*SLICE_W +: SLICE_W] == base_q[s*SLICE_W +: SLICE_W];
            end
        end
    end

    // Lexicographic merge with the most significant slice deciding first
    always_comb begin
        cur_lt_base = 1'b0;
        cur_eq_base = 1'b1;
        for (int s = NUM_SLICES - 1; s >= 0; s--) begin
            cur_lt_base = cur_lt_base | (cur_eq_base & slice_lt[s]);
            cur_eq_base = cur_eq_base & slice_eq[s];
        end
    end

    // --------------------
    // Cycle 3 result and past-base check
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            o_time_reached  <= 1'b0;
            o_base_time_err <= 1'b0;
        end else begin
            // Flags still hold the old base for two cycles after a strobe
            o_time_reached <= !(i_base_time_vld || vld_d1) && !cur_lt_base;
            if (i_base_time_vld) begin
                o_base_time_err <= 1'b0;
            end else if (vld_d2) begin
                o_base_time_err <= !cur_lt_base && !cur_eq_base;
            end
        end
    end

endmodule

/* rtl/gate_list_sched.sv */
// Needs i_interval_ns a nonzero multiple of TICK_NS; a refresh keeps the active bank index
`timescale 1ns/100ps

module gate_list_sched import qbv_pkg::*; (
    input  logic            i_clk,
    input  logic            i_rst,
    gcl_wr_if.monitor       wr,
    input  gcl_addr_t       i_done_len,
    input  logic            i_time_reached,
    input  logic            i_base_time_err,
    input  logic            i_base_time_vld,
    input  interval_t       i_interval_ns,
    input  logic            i_refresh_list,
    input  logic            i_qbv_en,
    input  gate_vec_t       i_queue,
    input  logic            i_queue_vld,
    output logic            o_active_bank,
    output logic            o_rd_en,
    output gcl_addr_t       o_rd_addr,
    input  gate_vec_t       i_rd_data,
    output gate_vec_t       o_gate_state,
    output logic            o_gate_state_vld,
    output logic            o_list_empty_err
);

    sched_state_t          state;
    logic                  active_bank;
    logic                  pending;         // Shadow bank holds a newer list
    logic                  list_ok;         // A list completed since reset or refresh
    logic                  base_ok;         // Base time accepted for that list
    gcl_addr_t             act_len;
    gcl_addr_t             pend_len;
    gcl_addr_t             idx;
    interval_t             tick_cnt;
    logic                  tick_end;
    logic                  last_idx;
    logic [RD_LATENCY-1:0] rd_pipe;
    gate_vec_t             gate_q;
    gate_vec_t             queue_q;

    assign tick_end      = (tick_cnt == i_interval_ns - interval_t'(TICK_NS));
    assign last_idx      = (idx == act_len - gcl_addr_t'(1));
    assign o_active_bank = active_bank;
    assign o_rd_addr     = idx;

    // --------------------
    // Run FSM, list bookkeeping, entry stepping
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            state       <= SCHED_IDLE;
            active_bank <= 1'b0;
            pending     <= 1'b0;
            list_ok     <= 1'b0;
            base_ok     <= 1'b0;
            act_len     <= '0;
            pend_len    <= '0;
            idx         <= '0;
            tick_cnt    <= '0;
            o_rd_en     <= 1'b0;
        end else begin
            o_rd_en <= 1'b0;
            if (i_refresh_list) begin
                state   <= SCHED_IDLE;
                pending <= 1'b0;
                list_ok <= 1'b0;
                base_ok <= 1'b0;
            end else begin
                if (i_base_time_vld) begin
                    base_ok <= list_ok || wr.bank_done;
                end
                if (wr.bank_done) begin
                    list_ok <= 1'b1;
                    if (state == SCHED_RUN) begin
                        pending  <= 1'b1;               // Swap at end of pass
                        pend_len <= i_done_len;
                    end else begin
                        active_bank <= wr.wr_bank;      // Nothing running so take it now
                        act_len     <= i_done_len;
                    end
                end
                case (state)
                    SCHED_IDLE: begin
                        if (list_ok && !i_base_time_err) begin
                            state <= SCHED_ARMED;
                        end
                    end
                    SCHED_ARMED: begin
                        if (i_time_reached && base_ok && !i_base_time_err) begin
                            state    <= SCHED_RUN;
                            idx      <= '0;
                            tick_cnt <= '0;
                            o_rd_en  <= 1'b1;           // Fetch entry 0
                        end
                    end
                    SCHED_RUN: begin
                        if (tick_end) begin
                            tick_cnt <= '0;
                            o_rd_en  <= 1'b1;
                            if (last_idx) begin
                                idx <= '0;
                                if (pending) begin
                                    active_bank <= ~active_bank;
                                    act_len     <= wr.bank_done ? i_done_len : pend_len;
                                    pending     <= 1'b0;
                                end
                            end else begin
                                idx <= idx + gcl_addr_t'(1);
                            end
                        end else begin
                            tick_cnt <= tick_cnt + interval_t'(TICK_NS);
                        end
                    end
                    default: state <= SCHED_IDLE;
                endcase
            end
        end
    end

    // --------------------
    // Gate register and queue output stage
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            rd_pipe          <= '0;
            gate_q           <= '0;
            queue_q          <= '0;
            o_gate_state_vld <= 1'b0;
            o_list_empty_err <= 1'b0;
        end else begin
            rd_pipe <= {rd_pipe[RD_LATENCY-2:0], o_rd_en};
            if (i_refresh_list) begin
                rd_pipe <= '0;                          // Drop reads in flight
                gate_q  <= '0;                          // All gates closed
            end else if (rd_pipe[RD_LATENCY-1]) begin
                gate_q <= i_rd_data;
            end
            if (i_queue_vld) begin
                queue_q <= i_queue;
            end
            o_gate_state_vld <= i_queue_vld;
            o_list_empty_err <= i_base_time_vld && !list_ok && !wr.bank_done;
        end
    end

    assign o_gate_state = i_qbv_en ? (queue_q & gate_q) : queue_q;

endmodule

/* rtl/gcl_banks.sv */
// Two list RAMs; read data lags i_rd_en by RD_LATENCY cycles and holds between reads
`timescale 1ns/100ps

module gcl_banks import qbv_pkg::*; (
    input  logic            i_clk,
    input  logic            i_rst,
    gcl_wr_if.banks         wr,
    input  logic            i_rd_bank,
    input  logic            i_rd_en,
    input  gcl_addr_t       i_rd_addr,
    output gate_vec_t       o_rd_data
);

    gate_vec_t mem0 [GCL_DEPTH];
    gate_vec_t mem1 [GCL_DEPTH];
    gate_vec_t mem_q;

    // --------------------
    // Write ports
    always_ff @(posedge i_clk) begin
        if (wr.wr_en && !wr.wr_bank) begin
            mem0[wr.wr_addr] <= wr.wr_data;
        end
        if (wr.wr_en && wr.wr_bank) begin
            mem1[wr.wr_addr] <= wr.wr_data;
        end
    end

    // --------------------
    // Registered read
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            mem_q     <= '0;
            o_rd_data <= '0;
        end else begin
            if (i_rd_en) begin
                mem_q <= i_rd_bank ? mem1[i_rd_addr] : mem0[i_rd_addr];
            end
            o_rd_data <= mem_q;                         // Second read stage
        end
    end

endmodule

/* rtl/gcl_loader.sv */
// Lists must arrive as i_list_len back-to-back valid cycles with the length held steady
`timescale 1ns/100ps

module gcl_loader import qbv_pkg::*; (
    input  logic            i_clk,
    input  logic            i_rst,
    input  gate_vec_t       i_list_state,
    input  gcl_addr_t       i_list_len,
    input  logic            i_list_vld,
    input  logic            i_active_bank,
    output gcl_addr_t       o_done_len,
    gcl_wr_if.loader        wr
);

    gcl_addr_t entry_cnt;
    logic      last_entry;

    assign last_entry = (entry_cnt == i_list_len - gcl_addr_t'(1));

    // Shadow bank is never the one being read
    assign wr.wr_bank = ~i_active_bank;

    // --------------------
    // Entry counter and strobes
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            entry_cnt    <= '0;
            wr.wr_en     <= 1'b0;
            wr.bank_done <= 1'b0;
        end else begin
            wr.wr_en     <= i_list_vld;
            wr.bank_done <= i_list_vld && last_entry;
            if (i_list_vld) begin
                if (last_entry) begin
                    entry_cnt <= '0;                    // Ready for next list
                end else begin
                    entry_cnt <= entry_cnt + gcl_addr_t'(1);
                end
            end
        end
    end

    // --------------------
    // Write payload
    always_ff @(posedge i_clk) begin
        if (i_list_vld) begin
            wr.wr_addr <= entry_cnt;
            wr.wr_data <= i_list_state;
        end
        if (i_list_vld && last_entry) begin
            o_done_len <= i_list_len;                   // Valid with bank_done
        end
    end

endmodule

/* rtl/gcl_wr_if.sv */
// Write path into the list banks; wr_bank is always the bank the scheduler is not reading
`timescale 1ns/100ps

interface gcl_wr_if import qbv_pkg::*; ();

    logic      wr_en;
    logic      wr_bank;
    gcl_addr_t wr_addr;
    gate_vec_t wr_data;
    logic      bank_done;       // Last entry of a list written

    modport loader (
        output wr_en,
        output wr_bank,
        output wr_addr,
        output wr_data,
        output bank_done
    );

    modport banks (
        input  wr_en,
        input  wr_bank,
        input  wr_addr,
        input  wr_data
    );

    modport monitor (
        input  wr_bank,
        input  bank_done
    );

endinterface

/* rtl/qbv_gate_ctrl.sv */
// One egress port with no back-pressure; every list entry and strobe is taken when it arrives
`timescale 1ns/100ps

module qbv_gate_ctrl import qbv_pkg::*; (
    input  logic            i_clk,
    input  logic            i_rst,
    input  gate_vec_t       i_list_state,
    input  gcl_addr_t       i_list_len,
    input  logic            i_list_vld,
    input  ptp_time_t       i_base_time,
    input  logic            i_base_time_vld,
    input  ptp_time_t       i_current_time,
    input  interval_t       i_interval_ns,
    input  logic            i_refresh_list,
    input  logic            i_qbv_en,
    input  gate_vec_t       i_queue,
    input  logic            i_queue_vld,
    output gate_vec_t       o_gate_state,
    output logic            o_gate_state_vld,
    output logic            o_base_time_err,
    output logic            o_list_empty_err
);

    gcl_addr_t done_len;
    logic      active_bank;
    logic      rd_en;
    gcl_addr_t rd_addr;
    gate_vec_t rd_data;
    logic      time_reached;

    gcl_wr_if u_wr_if ();

    // --------------------
    gcl_loader u_loader (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_list_state   (i_list_state),
        .i_list_len     (i_list_len),
        .i_list_vld     (i_list_vld),
        .i_active_bank  (active_bank),
        .o_done_len     (done_len),
        .wr             (u_wr_if.loader)
    );

    gcl_banks u_banks (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .wr             (u_wr_if.banks),
        .i_rd_bank      (active_bank),
        .i_rd_en        (rd_en),
        .i_rd_addr      (rd_addr),
        .o_rd_data      (rd_data)
    );

    base_time_cmp u_cmp (
        .i_clk           (i_clk),
        .i_rst           (i_rst),
        .i_current_time  (i_current_time),
        .i_base_time     (i_base_time),
        .i_base_time_vld (i_base_time_vld),
        .o_time_reached  (time_reached),
        .o_base_time_err (o_base_time_err)
    );

    gate_list_sched u_sched (
        .i_clk            (i_clk),
        .i_rst            (i_rst),
        .wr               (u_wr_if.monitor),
        .i_done_len       (done_len),
        .i_time_reached   (time_reached),
        .i_base_time_err  (o_base_time_err),
        .i_base_time_vld  (i_base_time_vld),
        .i_interval_ns    (i_interval_ns),
        .i_refresh_list   (i_refresh_list),
        .i_qbv_en         (i_qbv_en),
        .i_queue          (i_queue),
        .i_queue_vld      (i_queue_vld),
        .o_active_bank    (active_bank),
        .o_rd_en          (rd_en),
        .o_rd_addr        (rd_addr),
        .i_rd_data        (rd_data),
        .o_gate_state     (o_gate_state),
        .o_gate_state_vld (o_gate_state_vld),
        .o_list_empty_err (o_list_empty_err)
    );

endmodule

/* rtl/qbv_pkg.sv */
// Fixed build for one egress port with 8 queues, 8 ns clock tick and 80-bit PTP time
package qbv_pkg;

    // --------------------
    // Port geometry
    localparam int NUM_QUEUES = 8;
    localparam int GCL_DEPTH  = 256;                    // Entries per list bank

    // --------------------
    // Time base
    localparam int TIME_W     = 80;
    localparam int SLICE_W    = 10;
    localparam int NUM_SLICES = TIME_W / SLICE_W;       // 8 slices of 10 bits
    localparam int TICK_NS    = 8;                      // 125 MHz clock

    // List bank read pipeline of memory reg plus output reg
    localparam int RD_LATENCY = 2;

    typedef logic [NUM_QUEUES-1:0]        gate_vec_t;   // One bit per gate or queue
    typedef logic [$clog2(GCL_DEPTH)-1:0] gcl_addr_t;
    typedef logic [TIME_W-1:0]            ptp_time_t;
    typedef logic [15:0]                  interval_t;   // Entry interval in ns

    typedef enum logic [1:0] {
        SCHED_IDLE  = 2'd0,
        SCHED_ARMED = 2'd1,                             // List loaded and waiting for base time
        SCHED_RUN   = 2'd2
    } sched_state_t;

endpackage

/* run.sh */
#!/bin/sh
# Build and run the testbench with Verilator; exit status follows the result line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -j 0 --top-module tb_qbv_gate_ctrl \
    -f all.f -o tb_qbv_sim || exit 1
out=$(./obj_dir/tb_qbv_sim)
echo "$out"
echo "$out" | grep -q "^Result: PASSED$" && exit 0 || exit 1
